//--- exe.sv
module exe (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stall,
    input  exe_core_pkg::t_uinstr      uinstr_rd1,
    input  exe_core_pkg::t_rv_reg_data rddatas_rd1 [1:0],
    input  logic                       br_mispred_rb1,
    output exe_core_pkg::t_uinstr      uinstr_ex1,
    output exe_core_pkg::t_rv_reg_data result_ex1,
    output exe_core_pkg::t_paddr       br_tgt_ex1
);

    exe_core_pkg::t_uinstr      uinstr_exx [1:exe_core_pkg::NUM_EX_STAGES];
    exe_core_pkg::t_rv_reg_data result_exx [1:exe_core_pkg::NUM_EX_STAGES];
    exe_core_pkg::t_paddr       tgt_exx [1:exe_core_pkg::NUM_EX_STAGES];

    exe_core_pkg::t_uinstr      uinstr_ql_ex0;
    exe_core_pkg::t_rv_reg_data src1val_ex0;
    exe_core_pkg::t_rv_reg_data src2reg_ex0;
    exe_core_pkg::t_rv_reg_data src2val_ex0;
    exe_core_pkg::t_rv_reg_data result_ex0;
    logic                       byp1_ex0;
    logic                       byp2_ex0;

    logic                       ialu_resvld_ex0;
    exe_core_pkg::t_rv_reg_data ialu_result_ex0;
    logic                       ibr_resvld_ex0;
    exe_core_pkg::t_paddr       ibr_tgt_ex0;
    logic                       ibr_mispred_ex0;

    // EX1 to EX0 bypass, then immediate select
    always_comb begin
        byp1_ex0 = uinstr_ex1.valid && uinstr_ex1.dst_vld && uinstr_ex1.dst == uinstr_rd1.src1;
        byp2_ex0 = uinstr_ex1.valid && uinstr_ex1.dst_vld &&
                   uinstr_ex1.dst == uinstr_rd1.src2.idx;
        src1val_ex0 = byp1_ex0 ? result_ex1 : rddatas_rd1[0];
        src2reg_ex0 = byp2_ex0 ? result_ex1 : rddatas_rd1[1];
        src2val_ex0 = uinstr_rd1.src2.optype == rv_instr_pkg::OP_IMM ? uinstr_rd1.imm32
                                                                     : src2reg_ex0;
    end

    ialu ialu (
        .clk,
        .rst,
        .uinstr_ex0  (uinstr_rd1),
        .src1val_ex0,
        .src2val_ex0,
        .resvld_ex0  (ialu_resvld_ex0),
        .result_ex0  (ialu_result_ex0)
    );

    ibr ibr (
        .clk,
        .rst,
        .uinstr_ex0     (uinstr_rd1),
        .src1val_ex0,
        .src2val_ex0,
        .resvld_ex0     (ibr_resvld_ex0),
        .br_tgt_ex0     (ibr_tgt_ex0),
        .br_mispred_ex0 (ibr_mispred_ex0)
    );

    always_comb begin
        result_ex0  = '0;
        result_ex0 |= ialu_resvld_ex0 ? ialu_result_ex0 : '0;
        result_ex0 |= ibr_resvld_ex0 ? uinstr_rd1.pc + 32'd4 : '0;

        uinstr_ql_ex0 = uinstr_rd1;
        uinstr_ql_ex0.mispred = ibr_mispred_ex0;
    end

    // Entry entering EX1 is dropped behind a taken branch
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i <= exe_core_pkg::NUM_EX_STAGES; i++) begin
                uinstr_exx[i].valid <= 1'b0;
            end
        end else if (!stall) begin
            uinstr_exx[1] <= uinstr_ql_ex0;
            uinstr_exx[1].valid <= uinstr_ql_ex0.valid && !br_mispred_rb1;
            for (int i = 2; i <= exe_core_pkg::NUM_EX_STAGES; i++) begin
                uinstr_exx[i] <= uinstr_exx[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            result_exx[1] <= result_ex0;
            tgt_exx[1] <= ibr_tgt_ex0;
            for (int i = 2; i <= exe_core_pkg::NUM_EX_STAGES; i++) begin
                result_exx[i] <= result_exx[i-1];
                tgt_exx[i] <= tgt_exx[i-1];
            end
        end
    end

    assign uinstr_ex1 = uinstr_exx[exe_core_pkg::NUM_EX_STAGES];
    assign result_ex1 = result_exx[exe_core_pkg::NUM_EX_STAGES];
    assign br_tgt_ex1 = tgt_exx[exe_core_pkg::NUM_EX_STAGES];

endmodule

//--- exe_core_pkg.sv
package exe_core_pkg;

    localparam int NUM_EX_STAGES = 1;

    typedef logic [31:0] t_rv_reg_data;
    typedef logic [31:0] t_paddr;
    typedef logic [4:0]  t_rv_reg_idx;

    typedef struct packed {
        t_rv_reg_idx           idx;
        rv_instr_pkg::t_optype optype;
    } t_src2;

    typedef struct packed {
        logic               valid;
        rv_instr_pkg::t_uop uop;
        t_paddr             pc;
        t_rv_reg_idx        src1;
        t_src2              src2;
        t_rv_reg_idx        dst;
        logic               dst_vld;
        t_rv_reg_data       imm32;
        // Taken branch resolved in EX0
        logic               mispred;
        logic               illegal;
    } t_uinstr;

    typedef struct packed {
        logic         valid;
        t_paddr       pc;
        t_rv_reg_idx  dst;
        logic         dst_vld;
        t_rv_reg_data result;
        logic         illegal;
    } t_retire;

    typedef struct packed {
        logic   valid;
        t_paddr pc;
    } t_redirect;

endpackage

//--- exe_pipe_assertions.sv
module exe_pipe_assertions (
    input logic                       clk,
    input logic                       rst,
    input logic                       stall,
    input logic                       ialu_resvld_ex0,
    input logic                       ibr_resvld_ex0,
    input exe_core_pkg::t_uinstr      uinstr_ex1,
    input exe_core_pkg::t_rv_reg_data result_ex1
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // Results are ORed, so only one unit may drive
    one_result: assert property (@(posedge clk) disable iff (rst)
        !(ialu_resvld_ex0 && ibr_resvld_ex0))
        else begin
            fail_count++;
            $error("ialu and ibr both raised resvld");
        end

    ex1_hold: assert property (@(posedge clk) disable iff (rst)
        (uinstr_ex1.valid && stall) |=> ($stable(uinstr_ex1) && $stable(result_ex1)))
        else begin
            fail_count++;
            $error("EX1 content changed under stall");
        end

    no_retire_after_rst: assert property (@(posedge clk)
        rst |=> !uinstr_ex1.valid)
        else begin
            fail_count++;
            $error("EX1 valid right after reset");
        end

endmodule

bind exe exe_pipe_assertions asrt (
    .clk,
    .rst,
    .stall,
    .ialu_resvld_ex0,
    .ibr_resvld_ex0,
    .uinstr_ex1,
    .result_ex1
);

//--- exe_pipe_top.f
rv_instr_pkg.sv
exe_core_pkg.sv
uinstr_decode.sv
regfile.sv
ialu.sv
ibr.sv
exe.sv
exe_pipe_top.sv
exe_pipe_assertions.sv
exe_pipe_top_tb.sv

//--- exe_pipe_top.sv
module exe_pipe_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  logic                    instr_vld,
    input  rv_instr_pkg::t_rv_instr instr,
    input  exe_core_pkg::t_paddr    instr_pc,
    output exe_core_pkg::t_retire   retire,
    output exe_core_pkg::t_redirect redirect
);

    exe_core_pkg::t_uinstr      uinstr_dec;
    exe_core_pkg::t_uinstr      uinstr_rd1;
    exe_core_pkg::t_uinstr      uinstr_ex1;
    exe_core_pkg::t_rv_reg_idx  rd_idx [1:0];
    exe_core_pkg::t_rv_reg_data rddatas_dec [1:0];
    exe_core_pkg::t_rv_reg_data rddatas_rd1 [1:0];
    exe_core_pkg::t_rv_reg_data result_ex1;
    exe_core_pkg::t_paddr       br_tgt_ex1;
    logic                       br_mispred_rb1;

    uinstr_decode uinstr_decode (
        .instr,
        .pc     (instr_pc),
        .vld    (instr_vld),
        .uinstr (uinstr_dec)
    );

    assign rd_idx[0] = uinstr_dec.src1;
    assign rd_idx[1] = uinstr_dec.src2.idx;

    regfile regfile (
        .clk,
        .rst,
        .rd_idx,
        .rd_data (rddatas_dec),
        .wr_en   (retire.valid && retire.dst_vld),
        .wr_idx  (retire.dst),
        .wr_data (retire.result)
    );

    // rd1 stage holds the second squash slot
    always_ff @(posedge clk) begin
        if (rst) begin
            uinstr_rd1.valid <= 1'b0;
        end else if (!stall) begin
            uinstr_rd1 <= uinstr_dec;
            uinstr_rd1.valid <= uinstr_dec.valid && !br_mispred_rb1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            rddatas_rd1 <= rddatas_dec;
        end
    end

    exe exe (
        .clk,
        .rst,
        .stall,
        .uinstr_rd1,
        .rddatas_rd1,
        .br_mispred_rb1,
        .uinstr_ex1,
        .result_ex1,
        .br_tgt_ex1
    );

    assign br_mispred_rb1 = uinstr_ex1.valid && uinstr_ex1.mispred;

    always_comb begin
        retire.valid   = uinstr_ex1.valid && !stall;
        retire.pc      = uinstr_ex1.pc;
        retire.dst     = uinstr_ex1.dst;
        retire.dst_vld = uinstr_ex1.dst_vld;
        retire.result  = result_ex1;
        retire.illegal = uinstr_ex1.illegal;

        redirect.valid = br_mispred_rb1 && !stall;
        redirect.pc    = br_tgt_ex1;
    end

endmodule

//--- exe_pipe_top_tb.sv
module exe_pipe_top_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int     NUM_INSTR   = 2000;
    localparam int     CLK_NS      = 10;
    localparam longint WATCHDOG_NS = 20 * NUM_INSTR * CLK_NS * 4;

    typedef struct packed {
        exe_core_pkg::t_retire   ret;
        exe_core_pkg::t_redirect red;
    } t_expect;

    logic                    clk;
    logic                    rst;
    logic                    stall;
    logic                    instr_vld;
    rv_instr_pkg::t_rv_instr instr;
    exe_core_pkg::t_paddr    instr_pc;
    exe_core_pkg::t_retire   retire;
    exe_core_pkg::t_redirect redirect;

    logic [31:0]                rng;
    exe_core_pkg::t_rv_reg_data mregs [0:31];
    t_expect                    exp_q [$];
    int                         retired;
    int                         squashed;

    exe_pipe_top uut (
        .clk,
        .rst,
        .stall,
        .instr_vld,
        .instr,
        .instr_pc,
        .retire,
        .redirect
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        fail_run($sformatf("ERR %0t %s got=%h exp=%h", $time, name, got, exp));
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Reference ALU, indexed by funct3
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'b000: r = alt ? a - b : a + b;
            3'b001: r = a << b[4:0];
            3'b010: r = {31'b0, $signed(a) < $signed(b)};
            3'b011: r = {31'b0, a < b};
            3'b100: r = a ^ b;
            3'b101: begin
                if (alt)
                    r = $signed(a) >>> b[4:0];
                else
                    r = a >> b[4:0];
            end
            3'b110: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    task automatic make_word(output logic [31:0] w);
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;

        rng = xorshift(rng);
        r = rng;
        rng = xorshift(rng);
        s = rng;
        // Registers x0..x7 keep hazards frequent
        rd = {2'b00, r[2:0]};
        rs1 = {2'b00, r[5:3]};
        rs2 = {2'b00, r[8:6]};
        f3 = r[11:9];
        f7 = ((f3 == 3'b000 || f3 == 3'b101) && s[30]) ? 7'b0100000 : 7'b0000000;
        imm = s[11:0];
        if (r[15:12] == 4'h0) begin
            case (s[13:12])
                2'd0: w = {s[31:7], 7'b0000011};
                2'd1: w = {7'b0000001, rs2, rs1, f3, rd, rv_instr_pkg::OPC_OP};
                2'd2: w = {s[31:25], rs2, rs1, 3'b010, s[11:7], rv_instr_pkg::OPC_BRANCH};
                default: w = {s[31:7], 7'b1110011};
            endcase
        end else begin
            case (r[18:16])
                3'd0, 3'd1: w = {f7, rs2, rs1, f3, rd, rv_instr_pkg::OPC_OP};
                3'd2, 3'd3: begin
                    if (f3 == 3'b001)
                        imm[11:5] = 7'b0000000;
                    if (f3 == 3'b101)
                        imm[11:5] = f7;
                    w = {imm, rs1, f3, rd, rv_instr_pkg::OPC_OP_IMM};
                end
                3'd4: w = {s[31:12], rd, rv_instr_pkg::OPC_LUI};
                3'd5, 3'd6: begin
                    // Map reserved 010/011 onto BLTU/BGEU
                    if (f3[2:1] == 2'b01)
                        f3[2] = 1'b1;
                    w = {s[31:25], rs2, rs1, f3, s[11:7], rv_instr_pkg::OPC_BRANCH};
                end
                default: w = {s[31:12], rd, rv_instr_pkg::OPC_JAL};
            endcase
        end
    endtask

    // ISA step on the model register file
    task automatic model_exec(input logic [31:0] w, input exe_core_pkg::t_paddr pc,
                              output t_expect e);
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic        legal;
        logic        wr;
        logic        taken;

        rd = w[11:7];
        f3 = w[14:12];
        f7 = w[31:25];
        a = mregs[w[19:15]];
        b = mregs[w[24:20]];
        imm = '0;
        res = '0;
        legal = 1'b1;
        wr = 1'b0;
        taken = 1'b0;
        case (w[6:0])
            rv_instr_pkg::OPC_OP: begin
                wr = 1'b1;
                if (f7 == 7'b0000000) begin
                    res = alu_ref(f3, 1'b0, a, b);
                end else if (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101)) begin
                    res = alu_ref(f3, 1'b1, a, b);
                end else begin
                    legal = 1'b0;
                end
            end
            rv_instr_pkg::OPC_OP_IMM: begin
                wr = 1'b1;
                imm = {{20{w[31]}}, w[31:20]};
                if (f3 == 3'b001)
                    legal = f7 == 7'b0000000;
                if (f3 == 3'b101)
                    legal = f7 == 7'b0000000 || f7 == 7'b0100000;
                res = alu_ref(f3, f3 == 3'b101 && f7[5], a, imm);
            end
            rv_instr_pkg::OPC_LUI: begin
                wr = 1'b1;
                res = {w[31:12], 12'b0};
            end
            rv_instr_pkg::OPC_BRANCH: begin
                imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                case (f3)
                    3'b000: taken = a == b;
                    3'b001: taken = a != b;
                    3'b100: taken = $signed(a) < $signed(b);
                    3'b101: taken = $signed(a) >= $signed(b);
                    3'b110: taken = a < b;
                    3'b111: taken = a >= b;
                    default: legal = 1'b0;
                endcase
            end
            rv_instr_pkg::OPC_JAL: begin
                wr = 1'b1;
                taken = 1'b1;
                imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                res = pc + 32'd4;
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            wr = 1'b0;
            taken = 1'b0;
            res = '0;
        end
        e.ret.valid = 1'b1;
        e.ret.pc = pc;
        e.ret.dst = rd;
        e.ret.dst_vld = wr && rd != 5'd0;
        e.ret.result = res;
        e.ret.illegal = !legal;
        e.red.valid = taken;
        e.red.pc = pc + imm;
        if (e.ret.dst_vld)
            mregs[rd] = res;
    endtask

    task automatic check_retire(input exe_core_pkg::t_retire got,
                                input exe_core_pkg::t_retire exp);
        if (got.pc != exp.pc)
            report_mismatch("retire.pc", got.pc, exp.pc);
        if (got.illegal != exp.illegal)
            report_mismatch("retire.illegal", 32'(got.illegal), 32'(exp.illegal));
        if (got.dst_vld != exp.dst_vld)
            report_mismatch("retire.dst_vld", 32'(got.dst_vld), 32'(exp.dst_vld));
        if (exp.dst_vld && got.dst != exp.dst)
            report_mismatch("retire.dst", 32'(got.dst), 32'(exp.dst));
        if (exp.dst_vld && got.result != exp.result)
            report_mismatch("retire.result", got.result, exp.result);
    endtask

    task automatic check_redirect(input exe_core_pkg::t_redirect got,
                                  input exe_core_pkg::t_redirect exp);
        if (got.valid != exp.valid)
            report_mismatch("redirect.valid", 32'(got.valid), 32'(exp.valid));
        if (exp.valid && got.pc != exp.pc)
            report_mismatch("redirect.pc", got.pc, exp.pc);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run($sformatf("Watchdog expired after %0d ns, pipeline stopped retiring",
                           WATCHDOG_NS));
    end

    // Retire monitor at the falling edge
    initial begin
        t_expect e;
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (uut.exe.asrt.fail_count != 0)
                    fail_run("A pipeline assertion failed");
                if (redirect.valid && !retire.valid)
                    fail_run("Redirect raised in a cycle with no retire");
                if (retire.valid) begin
                    if (exp_q.size() == 0)
                        fail_run($sformatf("Extra retire of pc %h", retire.pc));
                    e = exp_q.pop_front();
                    check_retire(retire, e.ret);
                    check_redirect(redirect, e.red);
                    retired++;
                end
            end
        end
    end

    initial begin
        logic [31:0]          word;
        t_expect              e;
        int                   accepted;
        int                   slot;
        int                   squash_until;
        logic                 stall_b;
        logic                 vld_b;
        logic                 tgt_pending;
        exe_core_pkg::t_paddr pc;
        exe_core_pkg::t_paddr tgt;

        rng = 32'hd467e8ee;
        for (int i = 0; i < 32; i++)
            mregs[i] = '0;
        accepted = 0;
        slot = 0;
        squash_until = -1;
        tgt_pending = 1'b0;
        pc = 32'h0000_1000;
        tgt = '0;
        retired = 0;
        squashed = 0;
        rst = 1'b1;
        stall = 1'b0;
        instr_vld = 1'b0;
        instr = '0;
        instr_pc = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        while (accepted < NUM_INSTR) begin
            rng = xorshift(rng);
            stall_b = rng[1:0] == 2'b00;
            vld_b = rng[3:2] != 2'b00;
            make_word(word);
            if (!stall_b) begin
                // Bubbles also take a slot on an advancing edge
                slot++;
                if (vld_b) begin
                    accepted++;
                    if (slot <= squash_until) begin
                        squashed++;
                    end else begin
                        if (tgt_pending) begin
                            pc = tgt;
                            tgt_pending = 1'b0;
                        end
                        model_exec(word, pc, e);
                        exp_q.push_back(e);
                        if (e.red.valid) begin
                            squash_until = slot + 2;
                            tgt = e.red.pc;
                            tgt_pending = 1'b1;
                        end
                    end
                end
            end
            stall = stall_b;
            instr_vld = vld_b;
            instr = word;
            instr_pc = pc;
            if (!stall_b && vld_b)
                pc = pc + 32'd4;
            @(posedge clk);
            #1;
        end

        stall = 1'b0;
        instr_vld = 1'b0;
        for (int i = 0; i < 20 && exp_q.size() != 0; i++)
            @(posedge clk);
        repeat (4) @(posedge clk);
        $display("Accepted %0d, retired %0d, squashed %0d", accepted, retired, squashed);
        if (exp_q.size() == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("%0d accepted instructions never retired", exp_q.size());
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    end

endmodule

//--- ialu.sv
module ialu (
    input  logic                       clk,
    input  logic                       rst,
    input  exe_core_pkg::t_uinstr      uinstr_ex0,
    input  exe_core_pkg::t_rv_reg_data src1val_ex0,
    input  exe_core_pkg::t_rv_reg_data src2val_ex0,
    output logic                       resvld_ex0,
    output exe_core_pkg::t_rv_reg_data result_ex0
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    always_comb begin
        shamt = src2val_ex0[4:0];
        lt_signed = $signed(src1val_ex0) < $signed(src2val_ex0);
        lt_unsigned = src1val_ex0 < src2val_ex0;

        resvld_ex0 = uinstr_ex0.valid;
        case (uinstr_ex0.uop)
            rv_instr_pkg::U_ADD:  result_ex0 = src1val_ex0 + src2val_ex0;
            rv_instr_pkg::U_SUB:  result_ex0 = src1val_ex0 - src2val_ex0;
            rv_instr_pkg::U_AND:  result_ex0 = src1val_ex0 & src2val_ex0;
            rv_instr_pkg::U_OR:   result_ex0 = src1val_ex0 | src2val_ex0;
            rv_instr_pkg::U_XOR:  result_ex0 = src1val_ex0 ^ src2val_ex0;
            rv_instr_pkg::U_SLT:  result_ex0 = {31'b0, lt_signed};
            rv_instr_pkg::U_SLTU: result_ex0 = {31'b0, lt_unsigned};
            rv_instr_pkg::U_SLL:  result_ex0 = src1val_ex0 << shamt;
            rv_instr_pkg::U_SRL:  result_ex0 = src1val_ex0 >> shamt;
            rv_instr_pkg::U_SRA:  result_ex0 = $signed(src1val_ex0) >>> shamt;
            rv_instr_pkg::U_LUI:  result_ex0 = src2val_ex0;
            default: begin
                result_ex0 = '0;
                resvld_ex0 = 1'b0;
            end
        endcase
    end

endmodule

//--- ibr.sv
module ibr (
    input  logic                       clk,
    input  logic                       rst,
    input  exe_core_pkg::t_uinstr      uinstr_ex0,
    input  exe_core_pkg::t_rv_reg_data src1val_ex0,
    input  exe_core_pkg::t_rv_reg_data src2val_ex0,
    output logic                       resvld_ex0,
    output exe_core_pkg::t_paddr       br_tgt_ex0,
    output logic                       br_mispred_ex0
);

    logic eq;
    logic lt;
    logic ltu;
    logic taken;

    always_comb begin
        eq  = src1val_ex0 == src2val_ex0;
        lt  = $signed(src1val_ex0) < $signed(src2val_ex0);
        ltu = src1val_ex0 < src2val_ex0;

        case (uinstr_ex0.uop)
            rv_instr_pkg::U_BEQ:  taken = eq;
            rv_instr_pkg::U_BNE:  taken = !eq;
            rv_instr_pkg::U_BLT:  taken = lt;
            rv_instr_pkg::U_BGE:  taken = !lt;
            rv_instr_pkg::U_BLTU: taken = ltu;
            rv_instr_pkg::U_BGEU: taken = !ltu;
            rv_instr_pkg::U_JAL:  taken = 1'b1;
            default:              taken = 1'b0;
        endcase

        br_tgt_ex0 = uinstr_ex0.pc + uinstr_ex0.imm32;
        // Only JAL writes a link value
        resvld_ex0 = uinstr_ex0.valid && uinstr_ex0.uop == rv_instr_pkg::U_JAL;
        // Always predicted not-taken
        br_mispred_ex0 = uinstr_ex0.valid && taken;
    end

endmodule

//--- regfile.sv
module regfile (
    input  logic                       clk,
    input  logic                       rst,
    input  exe_core_pkg::t_rv_reg_idx  rd_idx [1:0],
    output exe_core_pkg::t_rv_reg_data rd_data [1:0],
    input  logic                       wr_en,
    input  exe_core_pkg::t_rv_reg_idx  wr_idx,
    input  exe_core_pkg::t_rv_reg_data wr_data
);

    // x0 has no storage
    exe_core_pkg::t_rv_reg_data regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Write-through covers the distance-two hazard
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            if (rd_idx[p] == '0) begin
                rd_data[p] = '0;
            end else if (wr_en && wr_idx == rd_idx[p]) begin
                rd_data[p] = wr_data;
            end else begin
                rd_data[p] = regs[rd_idx[p]];
            end
        end
    end

endmodule

//--- rv_instr_pkg.sv
package rv_instr_pkg;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 for branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } t_rtype;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } t_itype;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } t_btype;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } t_jtype;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } t_utype;

    // One instruction word, viewed by format
    typedef union packed {
        t_rtype r_type;
        t_itype i_type;
        t_btype b_type;
        t_jtype j_type;
        t_utype u_type;
    } t_rv_instr;

    typedef enum logic [5:0] {
        U_INVALID = 6'h00,
        // ALU group
        U_ADD     = 6'h10,
        U_SUB     = 6'h11,
        U_AND     = 6'h12,
        U_OR      = 6'h13,
        U_XOR     = 6'h14,
        U_SLT     = 6'h15,
        U_SLTU    = 6'h16,
        U_SLL     = 6'h17,
        U_SRL     = 6'h18,
        U_SRA     = 6'h19,
        U_LUI     = 6'h1a,
        // Branch group
        U_BEQ     = 6'h20,
        U_BNE     = 6'h21,
        U_BLT     = 6'h22,
        U_BGE     = 6'h23,
        U_BLTU    = 6'h24,
        U_BGEU    = 6'h25,
        U_JAL     = 6'h26
    } t_uop;

    typedef enum logic {
        OP_REG = 1'b0,
        OP_IMM = 1'b1
    } t_optype;

endpackage

//--- uinstr_decode.sv
module uinstr_decode (
    input  rv_instr_pkg::t_rv_instr instr,
    input  exe_core_pkg::t_paddr    pc,
    input  logic                    vld,
    output exe_core_pkg::t_uinstr   uinstr
);

    logic [2:0] f3;
    logic [6:0] f7;
    logic       writes_rd;

    // Shared funct3 map of OP and OP-IMM
    function automatic rv_instr_pkg::t_uop alu_uop(input logic [2:0] funct3, input logic alt);
        case (funct3)
            rv_instr_pkg::F3_ADD:  return alt ? rv_instr_pkg::U_SUB : rv_instr_pkg::U_ADD;
            rv_instr_pkg::F3_SLL:  return rv_instr_pkg::U_SLL;
            rv_instr_pkg::F3_SLT:  return rv_instr_pkg::U_SLT;
            rv_instr_pkg::F3_SLTU: return rv_instr_pkg::U_SLTU;
            rv_instr_pkg::F3_XOR:  return rv_instr_pkg::U_XOR;
            rv_instr_pkg::F3_SR:   return alt ? rv_instr_pkg::U_SRA : rv_instr_pkg::U_SRL;
            rv_instr_pkg::F3_OR:   return rv_instr_pkg::U_OR;
            default:               return rv_instr_pkg::U_AND;
        endcase
    endfunction

    always_comb begin
        f3 = instr.r_type.funct3;
        f7 = instr.r_type.funct7;
        writes_rd = 1'b0;

        uinstr = '0;
        uinstr.valid = vld;
        uinstr.pc = pc;
        uinstr.uop = rv_instr_pkg::U_INVALID;
        uinstr.src1 = instr.r_type.rs1;
        uinstr.src2.idx = instr.r_type.rs2;
        uinstr.src2.optype = rv_instr_pkg::OP_REG;
        uinstr.dst = instr.r_type.rd;

        case (instr.r_type.opcode)
            rv_instr_pkg::OPC_OP: begin
                writes_rd = 1'b1;
                if (f7 == rv_instr_pkg::F7_BASE) begin
                    uinstr.uop = alu_uop(f3, 1'b0);
                end else if (f7 == rv_instr_pkg::F7_ALT &&
                             (f3 == rv_instr_pkg::F3_ADD || f3 == rv_instr_pkg::F3_SR)) begin
                    uinstr.uop = alu_uop(f3, 1'b1);
                end
            end
            rv_instr_pkg::OPC_OP_IMM: begin
                writes_rd = 1'b1;
                uinstr.src2.optype = rv_instr_pkg::OP_IMM;
                uinstr.imm32 = {{20{instr.i_type.imm[11]}}, instr.i_type.imm};
                // Shift immediates carry funct7 in imm[11:5]
                if (f3 == rv_instr_pkg::F3_SLL || f3 == rv_instr_pkg::F3_SR) begin
                    if (f7 == rv_instr_pkg::F7_BASE) begin
                        uinstr.uop = alu_uop(f3, 1'b0);
                    end else if (f7 == rv_instr_pkg::F7_ALT && f3 == rv_instr_pkg::F3_SR) begin
                        uinstr.uop = rv_instr_pkg::U_SRA;
                    end
                end else begin
                    uinstr.uop = alu_uop(f3, 1'b0);
                end
            end
            rv_instr_pkg::OPC_LUI: begin
                writes_rd = 1'b1;
                uinstr.uop = rv_instr_pkg::U_LUI;
                uinstr.src2.optype = rv_instr_pkg::OP_IMM;
                uinstr.imm32 = {instr.u_type.imm31_12, 12'b0};
            end
            rv_instr_pkg::OPC_BRANCH: begin
                uinstr.imm32 = {{20{instr.b_type.imm12}}, instr.b_type.imm11,
                                instr.b_type.imm10_5, instr.b_type.imm4_1, 1'b0};
                case (f3)
                    rv_instr_pkg::F3_BEQ:  uinstr.uop = rv_instr_pkg::U_BEQ;
                    rv_instr_pkg::F3_BNE:  uinstr.uop = rv_instr_pkg::U_BNE;
                    rv_instr_pkg::F3_BLT:  uinstr.uop = rv_instr_pkg::U_BLT;
                    rv_instr_pkg::F3_BGE:  uinstr.uop = rv_instr_pkg::U_BGE;
                    rv_instr_pkg::F3_BLTU: uinstr.uop = rv_instr_pkg::U_BLTU;
                    rv_instr_pkg::F3_BGEU: uinstr.uop = rv_instr_pkg::U_BGEU;
                    default:               uinstr.uop = rv_instr_pkg::U_INVALID;
                endcase
            end
            rv_instr_pkg::OPC_JAL: begin
                writes_rd = 1'b1;
                uinstr.uop = rv_instr_pkg::U_JAL;
                uinstr.imm32 = {{12{instr.j_type.imm20}}, instr.j_type.imm19_12,
                                instr.j_type.imm11, instr.j_type.imm10_1, 1'b0};
            end
            default: uinstr.uop = rv_instr_pkg::U_INVALID;
        endcase

        uinstr.illegal = uinstr.uop == rv_instr_pkg::U_INVALID;
        // x0 and illegal words write nothing
        uinstr.dst_vld = writes_rd && !uinstr.illegal && uinstr.dst != '0;
    end

endmodule
